//--- src.f
+incdir+hw
hw/gt_link_pkg.sv
hw/cdr_lock_filter.sv
hw/align_word_detect.sv
hw/tx_word_mux.sv
hw/link_init_fsm.sv
hw/gt_link_top.sv
testbench/gt_link_props.sv
testbench/gt_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, result taken from sim.log
verilator --binary --timing --assert -f src.f --top-module gt_link_tb -o gt_link_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/gt_link_sim > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && exit 0 || exit 1

//--- testbench/gt_link_tb.sv
`timescale 1ns/1ps
`include "gt_link_consts.svh"

module gt_link_tb;

	localparam int CLK_NS = 8;
	localparam int LIMIT = `GT_TMO_LONG; // per wait loop
	localparam int BRINGUP = 2 * `GT_WAIT_CYCLES + `GT_CPLL_RESET_CYCLES
		+ 2 * `GT_GT_RESET_CYCLES + `GT_CDR_STABLE_CYCLES + 4 * `GT_ALIGN_HOLD_CYCLES + 16;
	localparam int TEST_CYCLES = 4 * BRINGUP + `GT_TMO_SHORT + 100;

	logic CPLLLOCKDETCLK;
	logic reset;
	logic [`GT_DWIDTH-1:0] rx_data_i;
	logic [`GT_DBYTE-1:0] rx_charisk_i;
	logic [`GT_DBYTE-1:0] rx_disperr_i;
	logic [`GT_DBYTE-1:0] rx_notintable_i;
	logic rx_byte_aligned_i;
	logic rx_cdr_lock_i;
	logic cpll_lock_i;
	logic cpll_refclk_lost_i;
	logic tx_reset_done_i;
	logic rx_reset_done_i;
	logic [`GT_DWIDTH-1:0] tx_user_data_i;
	logic [`GT_DBYTE-1:0] tx_user_charisk_i;
	logic cpll_reset_o;
	logic gt_tx_reset_o;
	logic gt_rx_reset_o;
	logic [`GT_DWIDTH-1:0] tx_data_o;
	logic [`GT_DBYTE-1:0] tx_charisk_o;
	logic link_up_o;

	int errors = 0;
	int checks = 0;
	integer seed = 32'h7d67;

	gt_link_top DUT (.*);

	always #(CLK_NS / 2) CPLLLOCKDETCLK = ~CPLLLOCKDETCLK;

	// far end loops our words back, so it echoes step 1 and step 2
	always @(negedge CPLLLOCKDETCLK) begin
		rx_data_i <= tx_data_o;
		rx_charisk_i <= tx_charisk_o;
	end

	task automatic expect_eq(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic flag_failure(bit ok, string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("%0t: %s", $time, what);
		end
	endtask

	task automatic wait_link_up();
		int n;
		bit s2;
		bit s3;
		n = 0;
		s2 = 0;
		s3 = 0;
		while (!link_up_o && n < LIMIT) begin
			if (tx_data_o == `GT_ALIGN2_WORD)
				s2 = 1;
			if (tx_data_o == `GT_ALIGN3_WORD && !s3) begin
				flag_failure(s2, "step-3 word sent before the step-2 word");
				s3 = 1;
			end
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		flag_failure(n < LIMIT, "link did not come up in time");
		flag_failure(s2 && s3, "alignment words missing before link up");
	endtask

	task automatic after_reset();
		expect_eq("cpll_reset_o", 32'(cpll_reset_o), 1);
		expect_eq("gt_tx_reset_o", 32'(gt_tx_reset_o), 1);
		expect_eq("gt_rx_reset_o", 32'(gt_rx_reset_o), 1);
		expect_eq("link_up_o", 32'(link_up_o), 0);
		expect_eq("tx_data_o", 32'(tx_data_o), 32'(`GT_ALIGN1_WORD));
		expect_eq("tx_charisk_o", 32'(tx_charisk_o), 32'(`GT_ALIGN_ISK));
	endtask

	task automatic reset_ordering();
		int n;
		cpll_lock_i = 1;
		tx_reset_done_i = 1;
		rx_reset_done_i = 1;
		rx_cdr_lock_i = 1;
		rx_byte_aligned_i = 1;
		n = 0;
		while (gt_tx_reset_o && n < LIMIT) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		while (!gt_tx_reset_o && n < LIMIT) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		expect_eq("cpll_reset_o", 32'(cpll_reset_o), 0); // released before the gt pulse
		while (gt_tx_reset_o && n < LIMIT) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		n = 0;
		while (!gt_rx_reset_o && n < LIMIT) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		flag_failure(n < LIMIT, "gt_rx_reset_o never pulsed");
		expect_eq("gt_tx_reset_o", 32'(gt_tx_reset_o), 0);
		expect_eq("cpll_reset_o", 32'(cpll_reset_o), 0);
		flag_failure(n >= `GT_WAIT_CYCLES + `GT_CDR_STABLE_CYCLES,
			"gt rx reset came before the cdr stability wait");
		n = 0;
		while (gt_rx_reset_o && n < LIMIT) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		flag_failure(n == `GT_GT_RESET_CYCLES, "gt_rx_reset_o pulse has the wrong length");
	endtask

	task automatic full_bring_up();
		logic [31:0] rnd;
		logic [`GT_DWIDTH-1:0] sent;
		logic [`GT_DBYTE-1:0] sent_k;
		wait_link_up();
		repeat (20) begin
			rnd = $random(seed);
			tx_user_data_i = rnd[`GT_DWIDTH-1:0];
			tx_user_charisk_i = rnd[`GT_DWIDTH +: `GT_DBYTE];
			sent = tx_user_data_i;
			sent_k = tx_user_charisk_i;
			@(negedge CPLLLOCKDETCLK);
			expect_eq("tx_data_o", 32'(tx_data_o), 32'(sent));
			expect_eq("tx_charisk_o", 32'(tx_charisk_o), 32'(sent_k));
		end
	endtask

	task automatic code_error_recovery();
		bit down;
		bit step1;
		down = 0;
		step1 = 0;
		rx_disperr_i = 2'b01;
		@(negedge CPLLLOCKDETCLK);
		rx_disperr_i = '0;
		repeat (8) begin
			if (!link_up_o)
				down = 1;
			if (tx_data_o == `GT_ALIGN1_WORD)
				step1 = 1;
			@(negedge CPLLLOCKDETCLK);
		end
		flag_failure(down, "link stayed up after a disparity error");
		flag_failure(step1, "step-1 word not sent after a disparity error");
		wait_link_up();
	endtask

	task automatic cdr_dropout();
		int n;
		rx_cdr_lock_i = 0;
		repeat (`GT_LOCK_MAX - 1) @(negedge CPLLLOCKDETCLK);
		rx_cdr_lock_i = 1;
		repeat (4) begin
			expect_eq("link_up_o", 32'(link_up_o), 1);
			@(negedge CPLLLOCKDETCLK);
		end
		rx_cdr_lock_i = 0;
		repeat (`GT_LOCK_MAX + 4) @(negedge CPLLLOCKDETCLK);
		expect_eq("link_up_o", 32'(link_up_o), 0);
		rx_cdr_lock_i = 1;
		n = 0;
		while (!gt_rx_reset_o && n < LIMIT) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		flag_failure(n < LIMIT, "gt_rx_reset_o did not pulse after cdr loss");
		wait_link_up();
	endtask

	task automatic pll_loss_timeout();
		int n;
		cpll_lock_i = 0;
		n = 0;
		while (cpll_reset_o !== 1'b0 || n == 0) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
			if (n >= LIMIT)
				break;
		end
		n = 0;
		while (!cpll_reset_o && n < LIMIT) begin
			@(negedge CPLLLOCKDETCLK);
			n++;
		end
		flag_failure(n >= `GT_TMO_SHORT && n <= `GT_TMO_SHORT + 8,
			"cpll_reset_o not reasserted near the short timeout");
		cpll_lock_i = 1;
	endtask

	initial begin
		#(6 * TEST_CYCLES * CLK_NS);
		$display("watchdog expired");
		$display("Test failures found");
		$finish;
	end

	initial begin
		CPLLLOCKDETCLK = 0;
		reset = 1;
		rx_data_i = '0;
		rx_charisk_i = '0;
		rx_disperr_i = '0;
		rx_notintable_i = '0;
		rx_byte_aligned_i = 0;
		rx_cdr_lock_i = 0;
		cpll_lock_i = 0;
		cpll_refclk_lost_i = 0;
		tx_reset_done_i = 0;
		rx_reset_done_i = 0;
		tx_user_data_i = '0;
		tx_user_charisk_i = '0;
		@(negedge CPLLLOCKDETCLK);
		after_reset();
		@(negedge CPLLLOCKDETCLK);
		reset = 0;
		reset_ordering();
		full_bring_up();
		code_error_recovery();
		cdr_dropout();
		pll_loss_timeout();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- testbench/gt_link_props.sv
`timescale 1ns/1ps

module gt_link_props import gt_link_pkg::*; (
	input logic CPLLLOCKDETCLK,
	input logic reset,
	input logic cpll_reset_o,
	input logic gt_tx_reset_o,
	input logic gt_rx_reset_o,
	input logic link_up_o,
	input logic [1:0] rx_disperr_i,
	input logic [1:0] rx_notintable_i,
	input link_state_t state
);

	// link up only with every reset released
	assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		link_up_o |-> !(cpll_reset_o || gt_tx_reset_o || gt_rx_reset_o))
		else $error("link up while a reset output is high");

	// outside power-up, the rx reset never overlaps the cpll reset
	assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		(cpll_reset_o && state != IDLE && state != TX_WAIT) |-> !gt_rx_reset_o)
		else $error("gt rx reset high during cpll reset");

	assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		(|{rx_disperr_i, rx_notintable_i}) |-> ##[1:3] !link_up_o)
		else $error("link stayed up after a code error");

endmodule

bind gt_link_top gt_link_props u_props (
	.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
	.reset(reset),
	.cpll_reset_o(cpll_reset_o),
	.gt_tx_reset_o(gt_tx_reset_o),
	.gt_rx_reset_o(gt_rx_reset_o),
	.link_up_o(link_up_o),
	.rx_disperr_i(rx_disperr_i),
	.rx_notintable_i(rx_notintable_i),
	.state(u_link_init_fsm.state)
);

//--- hw/gt_link_top.sv
`timescale 1ns/1ps
`include "gt_link_consts.svh"

module gt_link_top import gt_link_pkg::*; (
	input  logic CPLLLOCKDETCLK,
	input  logic reset,
	input  logic [`GT_DWIDTH-1:0] rx_data_i,
	input  logic [`GT_DBYTE-1:0] rx_charisk_i,
	input  logic [`GT_DBYTE-1:0] rx_disperr_i,
	input  logic [`GT_DBYTE-1:0] rx_notintable_i,
	input  logic rx_byte_aligned_i,
	input  logic rx_cdr_lock_i,
	input  logic cpll_lock_i,
	input  logic cpll_refclk_lost_i,
	input  logic tx_reset_done_i,
	input  logic rx_reset_done_i,
	input  logic [`GT_DWIDTH-1:0] tx_user_data_i,
	input  logic [`GT_DBYTE-1:0] tx_user_charisk_i,
	output logic cpll_reset_o,
	output logic gt_tx_reset_o,
	output logic gt_rx_reset_o,
	output logic [`GT_DWIDTH-1:0] tx_data_o,
	output logic [`GT_DBYTE-1:0] tx_charisk_o,
	output logic link_up_o
);

	logic cdr_locked;
	logic align1_seen;
	logic align2_seen;
	logic rx_err;
	tx_sel_t tx_sel;

	cdr_lock_filter u_cdr_lock_filter (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.rx_cdr_lock_i(rx_cdr_lock_i),
		.cdr_locked_o(cdr_locked)
	);

	align_word_detect u_align_word_detect (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.rx_data_i(rx_data_i),
		.rx_charisk_i(rx_charisk_i),
		.rx_disperr_i(rx_disperr_i),
		.rx_notintable_i(rx_notintable_i),
		.align1_seen_o(align1_seen),
		.align2_seen_o(align2_seen),
		.rx_err_o(rx_err)
	);

	link_init_fsm u_link_init_fsm (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.cpll_lock_i(cpll_lock_i),
		.cpll_refclk_lost_i(cpll_refclk_lost_i),
		.tx_reset_done_i(tx_reset_done_i),
		.rx_reset_done_i(rx_reset_done_i),
		.rx_byte_aligned_i(rx_byte_aligned_i),
		.cdr_locked_i(cdr_locked),
		.align1_seen_i(align1_seen),
		.align2_seen_i(align2_seen),
		.rx_err_i(rx_err),
		.cpll_reset_o(cpll_reset_o),
		.gt_tx_reset_o(gt_tx_reset_o),
		.gt_rx_reset_o(gt_rx_reset_o),
		.tx_sel_o(tx_sel),
		.link_up_o(link_up_o)
	);

	tx_word_mux u_tx_word_mux (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset(reset),
		.tx_sel_i(tx_sel),
		.tx_user_data_i(tx_user_data_i),
		.tx_user_charisk_i(tx_user_charisk_i),
		.tx_data_o(tx_data_o),
		.tx_charisk_o(tx_charisk_o)
	);

endmodule

//--- hw/link_init_fsm.sv
`timescale 1ns/1ps
`include "gt_link_consts.svh"

module link_init_fsm import gt_link_pkg::*; (
	input  logic CPLLLOCKDETCLK,
	input  logic reset,
	input  logic cpll_lock_i,
	input  logic cpll_refclk_lost_i,
	input  logic tx_reset_done_i,
	input  logic rx_reset_done_i,
	input  logic rx_byte_aligned_i,
	input  logic cdr_locked_i,
	input  logic align1_seen_i,
	input  logic align2_seen_i,
	input  logic rx_err_i,
	output logic cpll_reset_o,
	output logic gt_tx_reset_o,
	output logic gt_rx_reset_o,
	output tx_sel_t tx_sel_o,
	output logic link_up_o
);

	localparam int TW = `GT_TIMER_WIDTH;
	// last timer value of each counted state
	localparam logic [TW-1:0] WAIT_LAST = TW'(`GT_WAIT_CYCLES - 1);
	localparam logic [TW-1:0] CPLL_RST_LAST = TW'(`GT_CPLL_RESET_CYCLES - 1);
	localparam logic [TW-1:0] GT_RST_LAST = TW'(`GT_GT_RESET_CYCLES - 1);
	localparam logic [TW-1:0] CDR_STABLE_LAST = TW'(`GT_CDR_STABLE_CYCLES - 1);
	localparam logic [TW-1:0] HOLD_LAST = TW'(`GT_ALIGN_HOLD_CYCLES - 1);
	localparam logic [TW-1:0] TMO_SHORT = TW'(`GT_TMO_SHORT);
	localparam logic [TW-1:0] TMO_LONG = TW'(`GT_TMO_LONG);

	link_state_t state;
	link_state_t next;
	logic [TW-1:0] timer; // cycles spent in the current state
	logic tmo;
	logic tmo_long;
	logic pll_ok;
	logic far_aligned; // far end has shown the step-2 word

	assign tmo = (timer == TMO_SHORT);
	assign tmo_long = (timer == TMO_LONG);
	assign pll_ok = cpll_lock_i & ~cpll_refclk_lost_i;

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			timer <= '0;
		end
		else begin
			state <= next;
			timer <= (next == state) ? timer + 1'b1 : '0; // restart on every change
		end
	end

	always_comb begin
		next = state;
		case (state)
			IDLE: next = TX_WAIT;
			TX_WAIT: next = tmo ? TX_TMO : (timer == WAIT_LAST) ? CPLL_RESET : TX_WAIT;
			CPLL_RESET: next = tmo ? TX_TMO : (timer == CPLL_RST_LAST) ? CPLL_LOCKING : CPLL_RESET;
			CPLL_LOCKING: next = tmo ? TX_TMO : cpll_lock_i ? GT_TX_RESET : CPLL_LOCKING;
			GT_TX_RESET: next = tmo ? TX_TMO : (timer == GT_RST_LAST) ? GT_TX_RESETTING : GT_TX_RESET;
			GT_TX_RESETTING: begin
				if (tmo_long)
					next = TX_TMO;
				else if (tx_reset_done_i && pll_ok)
					next = RX_WAIT;
			end
			RX_WAIT: next = tmo ? RX_TMO : (timer == WAIT_LAST) ? RX_CDR_WAIT : RX_WAIT;
			RX_CDR_WAIT: next = cdr_locked_i ? RX_CDR_STABLE : RX_CDR_WAIT; // no timeout here
			RX_CDR_STABLE: begin
				if (!cdr_locked_i)
					next = RX_CDR_WAIT;
				else if (timer == CDR_STABLE_LAST)
					next = GT_RX_RESET;
			end
			GT_RX_RESET: next = tmo ? RX_TMO : (timer == GT_RST_LAST) ? GT_RX_RESETTING : GT_RX_RESET;
			GT_RX_RESETTING: begin
				if (tmo_long)
					next = RX_TMO;
				else if (tx_reset_done_i && rx_reset_done_i && pll_ok)
					next = ALIGN1;
			end
			ALIGN1, ALIGN2, ALIGN2_CHK, ALIGN3: begin
				if (tmo)
					next = RX_TMO;
				else if (!cdr_locked_i)
					next = RX_WAIT;
				else if (state == ALIGN1)
					next = rx_byte_aligned_i ? ALIGN2 : ALIGN1;
				else if (!rx_byte_aligned_i)
					next = ALIGN1; // lost the comma position
				else if (state == ALIGN2_CHK)
					next = far_aligned ? ALIGN3 : ALIGN2;
				else if (timer == HOLD_LAST)
					next = (state == ALIGN2) ? ALIGN2_CHK : DATA;
			end
			DATA: begin
				if (!pll_ok)
					next = TX_WAIT;
				else if (!cdr_locked_i)
					next = RX_WAIT;
				else if (rx_err_i)
					next = RX_ERR;
				else if (!rx_byte_aligned_i)
					next = ALIGN1;
				else if (align1_seen_i)
					next = ALIGN2; // far end restarted its alignment
				else if (align2_seen_i)
					next = ALIGN3;
			end
			RX_ERR: next = ALIGN1;
			TX_TMO: next = TX_WAIT;
			RX_TMO: next = RX_WAIT;
			default: next = IDLE;
		endcase
	end

	// outputs follow the state being entered, so they line up with state
	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			cpll_reset_o <= 1'b1;
			gt_tx_reset_o <= 1'b1;
			gt_rx_reset_o <= 1'b1;
			tx_sel_o <= SEL_ALIGN1;
			link_up_o <= 1'b0;
		end
		else begin
			case (next)
				TX_WAIT: begin
					cpll_reset_o <= 1'b1;
					gt_tx_reset_o <= 1'b1;
					gt_rx_reset_o <= 1'b1;
				end
				CPLL_RESET: begin
					cpll_reset_o <= 1'b1;
					gt_tx_reset_o <= 1'b0; // gt resets are pulsed after lock
					gt_rx_reset_o <= 1'b0;
				end
				CPLL_LOCKING: cpll_reset_o <= 1'b0;
				GT_TX_RESET: begin
					gt_tx_reset_o <= 1'b1;
					gt_rx_reset_o <= 1'b1;
				end
				GT_TX_RESETTING: begin
					gt_tx_reset_o <= 1'b0;
					gt_rx_reset_o <= 1'b0;
				end
				GT_RX_RESET: begin
					gt_tx_reset_o <= 1'b0;
					gt_rx_reset_o <= 1'b1;
				end
				GT_RX_RESETTING: gt_rx_reset_o <= 1'b0;
				default: ;
			endcase
			case (next)
				ALIGN2, ALIGN2_CHK: tx_sel_o <= SEL_ALIGN2;
				ALIGN3: tx_sel_o <= SEL_ALIGN3;
				DATA: tx_sel_o <= SEL_DATA;
				default: tx_sel_o <= SEL_ALIGN1;
			endcase
			link_up_o <= (next == DATA);
		end
	end

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset)
			far_aligned <= 1'b0;
		else if ((next != state) && (next == DATA || next == TX_WAIT))
			far_aligned <= 1'b0;
		else if (align2_seen_i && (state == ALIGN1 || state == ALIGN2 || state == ALIGN2_CHK))
			far_aligned <= 1'b1;
	end

endmodule

//--- hw/tx_word_mux.sv
`timescale 1ns/1ps
`include "gt_link_consts.svh"

module tx_word_mux import gt_link_pkg::*; (
	input  logic CPLLLOCKDETCLK,
	input  logic reset,
	input  tx_sel_t tx_sel_i,
	input  logic [`GT_DWIDTH-1:0] tx_user_data_i,
	input  logic [`GT_DBYTE-1:0] tx_user_charisk_i,
	output logic [`GT_DWIDTH-1:0] tx_data_o,
	output logic [`GT_DBYTE-1:0] tx_charisk_o
);

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			tx_data_o <= `GT_ALIGN1_WORD; // far end sees step 1 from the start
			tx_charisk_o <= `GT_ALIGN_ISK;
		end
		else begin
			case (tx_sel_i)
				SEL_ALIGN2: tx_data_o <= `GT_ALIGN2_WORD;
				SEL_ALIGN3: tx_data_o <= `GT_ALIGN3_WORD;
				SEL_DATA: tx_data_o <= tx_user_data_i;
				default: tx_data_o <= `GT_ALIGN1_WORD;
			endcase
			// user k-flags only in data mode
			if (tx_sel_i == SEL_DATA) begin
				tx_charisk_o <= tx_user_charisk_i;
			end
			else begin
				tx_charisk_o <= `GT_ALIGN_ISK;
			end
		end
	end

endmodule

//--- hw/align_word_detect.sv
`timescale 1ns/1ps
`include "gt_link_consts.svh"

module align_word_detect (
	input  logic CPLLLOCKDETCLK,
	input  logic reset,
	input  logic [`GT_DWIDTH-1:0] rx_data_i,
	input  logic [`GT_DBYTE-1:0] rx_charisk_i,
	input  logic [`GT_DBYTE-1:0] rx_disperr_i,
	input  logic [`GT_DBYTE-1:0] rx_notintable_i,
	output logic align1_seen_o,
	output logic align2_seen_o,
	output logic rx_err_o
);

	logic is_align1;
	logic is_align2;
	logic code_err;

	// word and k-flags must both match
	assign is_align1 = (rx_data_i == `GT_ALIGN1_WORD) && (rx_charisk_i == `GT_ALIGN_ISK);
	assign is_align2 = (rx_data_i == `GT_ALIGN2_WORD) && (rx_charisk_i == `GT_ALIGN_ISK);
	assign code_err = |{rx_disperr_i, rx_notintable_i}; // any byte, either kind

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			align1_seen_o <= 1'b0;
			align2_seen_o <= 1'b0;
			rx_err_o <= 1'b0;
		end
		else begin
			align1_seen_o <= is_align1;
			align2_seen_o <= is_align2;
			rx_err_o <= code_err;
		end
	end

endmodule

//--- hw/cdr_lock_filter.sv
`timescale 1ns/1ps
`include "gt_link_consts.svh"

module cdr_lock_filter (
	input  logic CPLLLOCKDETCLK,
	input  logic reset,
	input  logic rx_cdr_lock_i,
	output logic cdr_locked_o
);

	localparam int CW = $clog2(`GT_LOCK_MAX + 1);
	localparam logic [CW-1:0] LOCK_MAX = CW'(`GT_LOCK_MAX);

	logic [CW-1:0] unlock_cnt; // consecutive low samples

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			unlock_cnt <= '0;
			cdr_locked_o <= 1'b0;
		end
		else if (rx_cdr_lock_i) begin
			unlock_cnt <= '0;
			cdr_locked_o <= 1'b1;
		end
		else if (unlock_cnt != LOCK_MAX) begin
			unlock_cnt <= unlock_cnt + 1'b1; // short dropout, keep the flag
		end
		else begin
			cdr_locked_o <= 1'b0;
		end
	end

endmodule

//--- hw/gt_link_pkg.sv
package gt_link_pkg;

	// bring-up sequencer states
	typedef enum logic [4:0] {
		IDLE,
		TX_WAIT,
		CPLL_RESET,
		CPLL_LOCKING,
		GT_TX_RESET,
		GT_TX_RESETTING,
		RX_WAIT,
		RX_CDR_WAIT,
		RX_CDR_STABLE,
		GT_RX_RESET,
		GT_RX_RESETTING,
		ALIGN1,
		ALIGN2,
		ALIGN2_CHK,
		ALIGN3,
		DATA,
		RX_ERR,
		TX_TMO,
		RX_TMO
	} link_state_t;

	// what the transmitter puts on the lane
	typedef enum logic [1:0] {
		SEL_ALIGN1,
		SEL_ALIGN2,
		SEL_ALIGN3,
		SEL_DATA
	} tx_sel_t;

endpackage

//--- hw/gt_link_consts.svh
`ifndef GT_LINK_CONSTS_SVH
`define GT_LINK_CONSTS_SVH

// lane word and k-flag widths
`define GT_DWIDTH 16
`define GT_DBYTE 2

// alignment words, K28.5 in the low byte and the step number above it
`define GT_ALIGN1_WORD 16'h01bc
`define GT_ALIGN2_WORD 16'h02bc
`define GT_ALIGN3_WORD 16'h03bc
`define GT_ALIGN_ISK 2'b01 // only the low byte is a k-char

// state timer
`define GT_TIMER_WIDTH 16

// counted state lengths, in CPLLLOCKDETCLK cycles
`define GT_WAIT_CYCLES 20
`define GT_CPLL_RESET_CYCLES 2
`define GT_GT_RESET_CYCLES 10
`define GT_CDR_STABLE_CYCLES 64
`define GT_ALIGN_HOLD_CYCLES 16

// timeouts
`define GT_TMO_SHORT 1024
`define GT_TMO_LONG 4096 // RESETTING states only

// extra low samples tolerated on the raw cdr lock
`define GT_LOCK_MAX 3

`endif
